//--- hw/dcache_pkg.sv
package dcache_pkg;

   localparam int VADDR_W     = 32;
   localparam int PADDR_W     = 15;
   localparam int PAGE_OFS_W  = 12;
   localparam int VPN_W       = 20;
   localparam int TLB_ENTRIES = 8;

   localparam int LINE_BYTES  = 16;
   localparam int LINE_W      = LINE_BYTES * 8;
   localparam int DATA_W      = 64;
   localparam int OFS_W       = 4;
   localparam int IDX_W       = 3;
   localparam int BANK_SETS   = 8;
   localparam int TAG_W       = 7;

   localparam int AQ_DEPTH    = 4;
   localparam int AQ_PTR_W    = 2;
   localparam int ID_W        = 7;

   // 0..3 encode 1, 2, 4, 8 bytes
   typedef logic [1:0] size_t;

   typedef struct packed {
      logic [VPN_W-1:0] vpn;
      logic [VPN_W-1:0] pfn;
      logic             valid;
      logic             present;
      logic             writable;
   } tlb_entry_t;

   typedef struct packed {
      size_t           size;
      logic [ID_W-1:0] id;
   } rd_payload_t;

   typedef struct packed {
      size_t             size;
      logic [DATA_W-1:0] data;
   } wb_payload_t;

   typedef struct packed {
      logic [PADDR_W-1:0] paddr;
      rd_payload_t        payload;
   } rd_req_t;

   typedef struct packed {
      logic [PADDR_W-1:0] paddr;
      wb_payload_t        payload;
   } wb_req_t;

   typedef struct packed {
      logic               write;
      logic [PADDR_W-1:0] paddr;
      size_t              size;
      logic [DATA_W-1:0]  data;
      logic [ID_W-1:0]    id;
   } bank_req_t;

   typedef struct packed {
      logic              valid;
      logic              hit;
      logic [ID_W-1:0]   id;
      logic [OFS_W-1:0]  offset;
      size_t             size;
      logic [LINE_W-1:0] line;
   } bank_resp_t;

   typedef struct packed {
      logic              hit;
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
   } resp_t;

   // One bit per byte touched by an access of this size
   function automatic logic [DATA_W/8-1:0] size_bytes(size_t size);
      case (size)
         2'd0:    size_bytes = 8'h01;
         2'd1:    size_bytes = 8'h03;
         2'd2:    size_bytes = 8'h0f;
         default: size_bytes = 8'hff;
      endcase
   endfunction

endpackage

//--- hw/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup #(
   parameter type payload_t = dcache_pkg::rd_payload_t,
   parameter bit  IS_WRITE  = 1'b0
) (
   input  logic                             clk,
   input  logic                             rst_i,
   input  dcache_pkg::tlb_entry_t           tlb_i [dcache_pkg::TLB_ENTRIES],
   input  logic                             valid_i,
   input  logic [dcache_pkg::VADDR_W-1:0]   vaddr_i,
   input  payload_t                         payload_i,
   output logic                             push_o,
   output logic [dcache_pkg::PADDR_W-1:0]   paddr_o,
   output payload_t                         payload_o,
   output logic                             tlb_miss_o,
   output logic                             prot_fault_o
);
   import dcache_pkg::*;

   logic [TLB_ENTRIES-1:0] match;
   logic                   hit;
   logic                   fault;
   tlb_entry_t             sel;
   logic [PADDR_W-1:0]     paddr;

   // All entries compared at once
   always_comb begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
         match[i] = tlb_i[i].valid && (tlb_i[i].vpn == vaddr_i[VADDR_W-1:PAGE_OFS_W]);
      end
   end

   // Lowest index wins, so scan downwards
   always_comb begin
      sel = '0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (match[i]) begin
            sel = tlb_i[i];
         end
      end
   end

   assign hit   = |match;
   assign fault = hit && (!sel.present || (IS_WRITE && !sel.writable));
   assign paddr = {sel.pfn[PADDR_W-PAGE_OFS_W-1:0], vaddr_i[PAGE_OFS_W-1:0]};

   always_ff @(posedge clk) begin
      if (rst_i) begin
         push_o       <= 1'b0;
         tlb_miss_o   <= 1'b0;
         prot_fault_o <= 1'b0;
      end else begin
         push_o       <= valid_i && hit && !fault;
         tlb_miss_o   <= valid_i && !hit;
         prot_fault_o <= valid_i && fault;
      end
   end

   always_ff @(posedge clk) begin
      paddr_o   <= paddr;
      payload_o <= payload_i;
   end

endmodule

//--- hw/access_queue.sv
`timescale 1ns/1ps

module access_queue #(
   parameter type item_t = dcache_pkg::rd_req_t
) (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  push_i,
   input  item_t item_i,
   input  logic  pop_i,
   output item_t head_o,
   output logic  not_empty_o,
   output logic  full_o
);
   import dcache_pkg::*;

   item_t               mem [AQ_DEPTH];
   logic [AQ_PTR_W-1:0] wr_ptr;
   logic [AQ_PTR_W-1:0] rd_ptr;
   logic [AQ_PTR_W:0]   count;
   logic                do_push;
   logic                do_pop;

   assign full_o      = (count == (AQ_PTR_W + 1)'(AQ_DEPTH));
   assign not_empty_o = (count != '0);
   assign head_o      = mem[rd_ptr];

   // Push on a full queue is lost
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && not_empty_o;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= item_i;
      end
   end

endmodule

//--- hw/queue_arbiter.sv
`timescale 1ns/1ps

module queue_arbiter (
   input  dcache_pkg::rd_req_t   rd_head_i,
   input  logic                  rd_not_empty_i,
   input  dcache_pkg::wb_req_t   wb_head_i,
   input  logic                  wb_not_empty_i,
   output logic                  rd_pop_o,
   output logic                  wb_pop_o,
   output logic                  even_valid_o,
   output logic                  odd_valid_o,
   output dcache_pkg::bank_req_t bank_req_o
);
   import dcache_pkg::*;

   logic any_pop;

   // Writes always go first
   assign wb_pop_o = wb_not_empty_i;
   assign rd_pop_o = rd_not_empty_i && !wb_not_empty_i;
   assign any_pop  = wb_pop_o || rd_pop_o;

   always_comb begin
      if (wb_not_empty_i) begin
         bank_req_o.write = 1'b1;
         bank_req_o.paddr = wb_head_i.paddr;
         bank_req_o.size  = wb_head_i.payload.size;
         bank_req_o.data  = wb_head_i.payload.data;
         bank_req_o.id    = '0;
      end else begin
         bank_req_o.write = 1'b0;
         bank_req_o.paddr = rd_head_i.paddr;
         bank_req_o.size  = rd_head_i.payload.size;
         bank_req_o.data  = '0;
         bank_req_o.id    = rd_head_i.payload.id;
      end
   end

   // Bit above the line offset picks the bank
   assign even_valid_o = any_pop && !bank_req_o.paddr[OFS_W];
   assign odd_valid_o  = any_pop && bank_req_o.paddr[OFS_W];

endmodule

//--- hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   req_valid_i,
   input  dcache_pkg::bank_req_t  req_i,
   output dcache_pkg::bank_resp_t resp_o
);
   import dcache_pkg::*;

   logic [BANK_SETS-1:0] line_vld_q;
   logic [TAG_W-1:0]     tag_q  [BANK_SETS];
   logic [LINE_W-1:0]    line_q [BANK_SETS];

   logic [IDX_W-1:0]      idx;
   logic [TAG_W-1:0]      tag;
   logic [OFS_W-1:0]      ofs;
   logic                  hit;
   logic                  wr_en;
   logic [LINE_BYTES-1:0] byte_en;
   logic [LINE_W-1:0]     wr_line;
   logic [LINE_W-1:0]     base_line;
   logic [LINE_W-1:0]     new_line;

   assign idx   = req_i.paddr[OFS_W+1 +: IDX_W];
   assign tag   = req_i.paddr[PADDR_W-1 -: TAG_W];
   assign ofs   = req_i.paddr[OFS_W-1:0];
   assign hit   = line_vld_q[idx] && (tag_q[idx] == tag);
   assign wr_en = req_valid_i && req_i.write;

   assign byte_en = LINE_BYTES'(size_bytes(req_i.size)) << ofs;
   assign wr_line = LINE_W'(req_i.data) << {ofs, 3'b000};

   // Missing line starts from zero under the new tag
   assign base_line = hit ? line_q[idx] : '0;

   always_comb begin
      for (int b = 0; b < LINE_BYTES; b++) begin
         new_line[b*8 +: 8] = byte_en[b] ? wr_line[b*8 +: 8] : base_line[b*8 +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         line_vld_q <= '0;
      end else if (wr_en) begin
         line_vld_q[idx] <= 1'b1;
      end
      if (wr_en) begin
         tag_q[idx]  <= tag;
         line_q[idx] <= new_line;
      end
   end

   // Only reads produce a result
   always_ff @(posedge clk) begin
      if (rst_i) begin
         resp_o.valid <= 1'b0;
      end else begin
         resp_o.valid <= req_valid_i && !req_i.write;
      end
      resp_o.hit    <= hit;
      resp_o.id     <= req_i.id;
      resp_o.offset <= ofs;
      resp_o.size   <= req_i.size;
      resp_o.line   <= line_q[idx];
   end

endmodule

//--- hw/output_align.sv
`timescale 1ns/1ps

module output_align (
   input  logic                   clk,
   input  logic                   rst_i,
   input  dcache_pkg::bank_resp_t even_i,
   input  dcache_pkg::bank_resp_t odd_i,
   output logic                   resp_valid_o,
   output dcache_pkg::resp_t      resp_o
);
   import dcache_pkg::*;

   bank_resp_t          sel;
   logic [LINE_W-1:0]   shifted;
   logic [DATA_W/8-1:0] bmask;
   logic [DATA_W-1:0]   dmask;
   logic [DATA_W-1:0]   data;

   // At most one bank answers per cycle
   assign sel     = even_i.valid ? even_i : odd_i;
   assign shifted = sel.line >> {sel.offset, 3'b000};
   assign bmask   = size_bytes(sel.size);

   always_comb begin
      for (int b = 0; b < DATA_W / 8; b++) begin
         dmask[b*8 +: 8] = {8{bmask[b]}};
      end
   end

   assign data = sel.hit ? (shifted[DATA_W-1:0] & dmask) : '0;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= even_i.valid || odd_i.valid;
      end
      resp_o.hit  <= sel.hit;
      resp_o.id   <= sel.id;
      resp_o.data <= data;
   end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
   input  logic                           clk,
   input  logic                           rst_i,
   input  dcache_pkg::tlb_entry_t         tlb_i [dcache_pkg::TLB_ENTRIES],
   input  logic                           rd_valid_i,
   input  logic [dcache_pkg::VADDR_W-1:0] rd_vaddr_i,
   input  dcache_pkg::rd_payload_t        rd_payload_i,
   input  logic                           wb_valid_i,
   input  logic [dcache_pkg::VADDR_W-1:0] wb_vaddr_i,
   input  dcache_pkg::wb_payload_t        wb_payload_i,
   output logic                           rd_tlb_miss_o,
   output logic                           rd_prot_fault_o,
   output logic                           wb_tlb_miss_o,
   output logic                           wb_prot_fault_o,
   output logic                           rdaq_full_o,
   output logic                           wbaq_full_o,
   output logic                           aq_empty_o,
   output logic                           resp_valid_o,
   output dcache_pkg::resp_t              resp_o
);
   import dcache_pkg::*;

   logic               rd_push, wb_push;
   logic [PADDR_W-1:0] rd_paddr, wb_paddr;
   rd_payload_t        rd_pl;
   wb_payload_t        wb_pl;
   rd_req_t            rd_item, rd_head;
   wb_req_t            wb_item, wb_head;
   logic               rd_not_empty, wb_not_empty;
   logic               rd_pop, wb_pop;
   logic               even_valid, odd_valid;
   bank_req_t          bank_req;
   bank_resp_t         even_resp, odd_resp;

   assign rd_item = '{paddr: rd_paddr, payload: rd_pl};
   assign wb_item = '{paddr: wb_paddr, payload: wb_pl};

   // Empty also covers a translated request about to be queued
   assign aq_empty_o = !(rd_not_empty || wb_not_empty || rd_push || wb_push);

   tlb_lookup #(.payload_t(rd_payload_t), .IS_WRITE(1'b0)) u_rd_tlb (
      .clk(clk), .rst_i(rst_i), .tlb_i(tlb_i),
      .valid_i(rd_valid_i), .vaddr_i(rd_vaddr_i), .payload_i(rd_payload_i),
      .push_o(rd_push), .paddr_o(rd_paddr), .payload_o(rd_pl),
      .tlb_miss_o(rd_tlb_miss_o), .prot_fault_o(rd_prot_fault_o)
   );

   tlb_lookup #(.payload_t(wb_payload_t), .IS_WRITE(1'b1)) u_wb_tlb (
      .clk(clk), .rst_i(rst_i), .tlb_i(tlb_i),
      .valid_i(wb_valid_i), .vaddr_i(wb_vaddr_i), .payload_i(wb_payload_i),
      .push_o(wb_push), .paddr_o(wb_paddr), .payload_o(wb_pl),
      .tlb_miss_o(wb_tlb_miss_o), .prot_fault_o(wb_prot_fault_o)
   );

   access_queue #(.item_t(rd_req_t)) u_rd_aq (
      .clk(clk), .rst_i(rst_i), .push_i(rd_push), .item_i(rd_item), .pop_i(rd_pop),
      .head_o(rd_head), .not_empty_o(rd_not_empty), .full_o(rdaq_full_o)
   );

   access_queue #(.item_t(wb_req_t)) u_wb_aq (
      .clk(clk), .rst_i(rst_i), .push_i(wb_push), .item_i(wb_item), .pop_i(wb_pop),
      .head_o(wb_head), .not_empty_o(wb_not_empty), .full_o(wbaq_full_o)
   );

   queue_arbiter u_arb (
      .rd_head_i(rd_head), .rd_not_empty_i(rd_not_empty),
      .wb_head_i(wb_head), .wb_not_empty_i(wb_not_empty),
      .rd_pop_o(rd_pop), .wb_pop_o(wb_pop),
      .even_valid_o(even_valid), .odd_valid_o(odd_valid), .bank_req_o(bank_req)
   );

   cache_bank u_bank_e (
      .clk(clk), .rst_i(rst_i), .req_valid_i(even_valid), .req_i(bank_req),
      .resp_o(even_resp)
   );

   cache_bank u_bank_o (
      .clk(clk), .rst_i(rst_i), .req_valid_i(odd_valid), .req_i(bank_req),
      .resp_o(odd_resp)
   );

   output_align u_align (
      .clk(clk), .rst_i(rst_i), .even_i(even_resp), .odd_i(odd_resp),
      .resp_valid_o(resp_valid_o), .resp_o(resp_o)
   );

endmodule

//--- dv/dcache_tb_table.svh
// Columns: name, operation, virtual address, size code, write data or read id,
// expected exception, expected hit, expected read data
task automatic load_tests();
   add_row("rd_unmapped", OP_RD, 32'hdeadb000, 2'd3, 64'h01, RD_MISS, 1'b0, 64'h0);
   add_row("wb_unmapped", OP_WR, 32'h55555010, 2'd3, 64'h1111, WB_MISS, 1'b0, 64'h0);
   add_row("wb_readonly", OP_WR, 32'h00777020, 2'd2, 64'hcafef00d, WB_FAULT, 1'b0, 64'h0);
   add_row("rd_absent", OP_RD, 32'h00999000, 2'd3, 64'h02, RD_FAULT, 1'b0, 64'h0);
   add_row("rd_readonly", OP_RD, 32'h00777020, 2'd2, 64'h03, NO_EXC, 1'b0, 64'h0);
   // Page 12345 maps to frame 3, page 00abc to frame 5
   add_row("wr8_even", OP_WR, 32'h12345040, 2'd3, 64'h8877665544332211, NO_EXC, 1'b0, 64'h0);
   add_row("wr4_even", OP_WR, 32'h12345048, 2'd2, 64'hffffffffddccbbaa, NO_EXC, 1'b0, 64'h0);
   add_row("wr2_odd", OP_WR, 32'h12345052, 2'd1, 64'hbeef, NO_EXC, 1'b0, 64'h0);
   add_row("wr1_odd", OP_WR, 32'h1234505f, 2'd0, 64'h5a, NO_EXC, 1'b0, 64'h0);
   add_row("wr8_page2", OP_WR, 32'h00abc0f8, 2'd3, 64'h0123456789abcdef, NO_EXC, 1'b0, 64'h0);
   add_row("rd8_even", OP_RD, 32'h12345040, 2'd3, 64'h10, NO_EXC, 1'b1, 64'h8877665544332211);
   add_row("rd4_even", OP_RD, 32'h12345048, 2'd2, 64'h11, NO_EXC, 1'b1, 64'hddccbbaa);
   add_row("rd2_even", OP_RD, 32'h12345043, 2'd1, 64'h12, NO_EXC, 1'b1, 64'h5544);
   add_row("rd1_even", OP_RD, 32'h12345047, 2'd0, 64'h13, NO_EXC, 1'b1, 64'h88);
   add_row("rd8_span", OP_RD, 32'h12345044, 2'd3, 64'h14, NO_EXC, 1'b1, 64'hddccbbaa88776655);
   add_row("rd4_odd", OP_RD, 32'h12345050, 2'd2, 64'h15, NO_EXC, 1'b1, 64'hbeef0000);
   add_row("rd8_odd", OP_RD, 32'h12345058, 2'd3, 64'h16, NO_EXC, 1'b1, 64'h5a00000000000000);
   add_row("rd2_page2", OP_RD, 32'h00abc0fa, 2'd1, 64'h17, NO_EXC, 1'b1, 64'h89ab);
   add_row("rd8_page2", OP_RD, 32'h00abc0f8, 2'd3, 64'h18, NO_EXC, 1'b1, 64'h0123456789abcdef);
   add_row("rd_cold", OP_RD, 32'h12345000, 2'd3, 64'h19, NO_EXC, 1'b0, 64'h0);
   // Same even index 2, new tag 31
   add_row("wr_evict", OP_WR, 32'h12345144, 2'd2, 64'h13579bdf, NO_EXC, 1'b0, 64'h0);
   add_row("rd_evicted", OP_RD, 32'h12345040, 2'd3, 64'h1a, NO_EXC, 1'b0, 64'h0);
   add_row("rd_new_zero", OP_RD, 32'h12345148, 2'd3, 64'h1b, NO_EXC, 1'b1, 64'h0);
   add_row("rd_new_word", OP_RD, 32'h12345144, 2'd2, 64'h1c, NO_EXC, 1'b1, 64'h13579bdf);
   add_row("rd_new_low", OP_RD, 32'h12345140, 2'd3, 64'h1d, NO_EXC, 1'b1, 64'h13579bdf00000000);
   // Reads from the id in the value column upwards, writes go to the even neighbour line
   add_row("burst", OP_BURST, 32'h00abc0f8, 2'd3, 64'h40, NO_EXC, 1'b1, 64'h0123456789abcdef);
endtask

//--- dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
   import dcache_pkg::*;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_BURST} op_t;

   // Same bit order as pulse_bits()
   typedef enum logic [3:0] {
      NO_EXC   = 4'b0000,
      WB_FAULT = 4'b0001,
      WB_MISS  = 4'b0010,
      RD_FAULT = 4'b0100,
      RD_MISS  = 4'b1000
   } exc_t;

   typedef struct packed {
      op_t                op;
      logic [VADDR_W-1:0] vaddr;
      size_t              size;
      logic [DATA_W-1:0]  value;
      exc_t               exc;
      logic               hit;
      logic [DATA_W-1:0]  exp_data;
   } test_row_t;

   localparam int WAIT_LIMIT = 40;

   logic               clk;
   logic               rst_i;
   tlb_entry_t         tlb [TLB_ENTRIES];
   logic               rd_valid_i;
   logic [VADDR_W-1:0] rd_vaddr_i;
   rd_payload_t        rd_payload_i;
   logic               wb_valid_i;
   logic [VADDR_W-1:0] wb_vaddr_i;
   wb_payload_t        wb_payload_i;
   logic               rd_tlb_miss_o, rd_prot_fault_o, wb_tlb_miss_o, wb_prot_fault_o;
   logic               rdaq_full_o, wbaq_full_o, aq_empty_o;
   logic               resp_valid_o;
   resp_t              resp_o;

   test_row_t rows [$];
   string     row_names [$];
   string     cur_name;
   int        row_errors;
   int        failed_tests;
   int        tests_run;

   dcache_top u_dcache_top (
      .clk(clk), .rst_i(rst_i), .tlb_i(tlb),
      .rd_valid_i(rd_valid_i), .rd_vaddr_i(rd_vaddr_i), .rd_payload_i(rd_payload_i),
      .wb_valid_i(wb_valid_i), .wb_vaddr_i(wb_vaddr_i), .wb_payload_i(wb_payload_i),
      .rd_tlb_miss_o(rd_tlb_miss_o), .rd_prot_fault_o(rd_prot_fault_o),
      .wb_tlb_miss_o(wb_tlb_miss_o), .wb_prot_fault_o(wb_prot_fault_o),
      .rdaq_full_o(rdaq_full_o), .wbaq_full_o(wbaq_full_o), .aq_empty_o(aq_empty_o),
      .resp_valid_o(resp_valid_o), .resp_o(resp_o)
   );

   always #10 clk = ~clk;

   function automatic logic [3:0] pulse_bits();
      return {rd_tlb_miss_o, rd_prot_fault_o, wb_tlb_miss_o, wb_prot_fault_o};
   endfunction

   task automatic add_row(string name, op_t op, logic [VADDR_W-1:0] vaddr, size_t size,
                          logic [DATA_W-1:0] value, exc_t exc, logic hit,
                          logic [DATA_W-1:0] exp_data);
      test_row_t r;
      r.op       = op;
      r.vaddr    = vaddr;
      r.size     = size;
      r.value    = value;
      r.exc      = exc;
      r.hit      = hit;
      r.exp_data = exp_data;
      rows.push_back(r);
      row_names.push_back(name);
   endtask

   task automatic compare_value(string what, logic [63:0] exp_v, logic [63:0] act_v);
      assert (act_v === exp_v) else begin
         $display("error %s: %s expected %h actual %h", cur_name, what, exp_v, act_v);
         row_errors++;
      end
   endtask

   task automatic report_failure(string msg);
      $display("%s: %s", cur_name, msg);
      row_errors++;
   endtask

   task automatic send_request(test_row_t row);
      @(posedge clk);
      #2;
      if (row.op == OP_WR) begin
         wb_valid_i        = 1'b1;
         wb_vaddr_i        = row.vaddr;
         wb_payload_i.size = row.size;
         wb_payload_i.data = row.value;
      end else begin
         rd_valid_i        = 1'b1;
         rd_vaddr_i        = row.vaddr;
         rd_payload_i.size = row.size;
         rd_payload_i.id   = row.value[ID_W-1:0];
      end
      @(posedge clk);
      #2;
      wb_valid_i = 1'b0;
      rd_valid_i = 1'b0;
   endtask

   // Pulse one cycle after the request and gone the cycle after
   task automatic check_pulses(test_row_t row);
      @(negedge clk);
      compare_value("exception pulses", 64'(row.exc), 64'(pulse_bits()));
      @(negedge clk);
      compare_value("pulses one cycle later", 64'd0, 64'(pulse_bits()));
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (!aq_empty_o && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!aq_empty_o) begin
         report_failure("access queues did not drain before the timeout");
      end
   endtask

   task automatic wait_response(output logic ok);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!resp_valid_o && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      ok = resp_valid_o;
   endtask

   task automatic expect_quiet(int n);
      repeat (n) begin
         @(negedge clk);
         compare_value("resp_valid_o", 64'd0, 64'(resp_valid_o));
      end
   endtask

   task automatic check_response(test_row_t row, logic [ID_W-1:0] id);
      logic ok;
      wait_response(ok);
      if (!ok) begin
         report_failure("no read response before the timeout");
      end else begin
         compare_value("hit", 64'(row.hit), 64'(resp_o.hit));
         compare_value("id", 64'(id), 64'(resp_o.id));
         compare_value("data", row.exp_data, resp_o.data);
      end
   endtask

   // Writes on every cycle hold all reads in their queue until it fills
   task automatic run_burst(test_row_t row);
      int issued;
      issued = 0;
      @(posedge clk);
      #2;
      while (!rdaq_full_o && issued < WAIT_LIMIT) begin
         wb_valid_i        = 1'b1;
         wb_vaddr_i        = row.vaddr ^ 32'h10;
         wb_payload_i.size = row.size;
         wb_payload_i.data = ~row.exp_data;
         rd_valid_i        = 1'b1;
         rd_vaddr_i        = row.vaddr;
         rd_payload_i.size = row.size;
         rd_payload_i.id   = row.value[ID_W-1:0] + ID_W'(issued);
         issued++;
         @(posedge clk);
         #2;
      end
      wb_valid_i = 1'b0;
      rd_valid_i = 1'b0;
      if (!rdaq_full_o) begin
         report_failure("read queue full flag never rose");
      end
      // Only the first AQ_DEPTH reads fit in the queue
      for (int n = 0; n < AQ_DEPTH; n++) begin
         check_response(row, row.value[ID_W-1:0] + ID_W'(n));
      end
      expect_quiet(6);
      wait_drained();
   endtask

   task automatic load_tlb();
      for (int k = 0; k < TLB_ENTRIES; k++) begin
         tlb[k] = '0;
      end
      tlb[0] = '{vpn: 20'h12345, pfn: 20'h3, valid: 1'b1, present: 1'b1, writable: 1'b1};
      tlb[1] = '{vpn: 20'h00abc, pfn: 20'h5, valid: 1'b1, present: 1'b1, writable: 1'b1};
      tlb[2] = '{vpn: 20'h00777, pfn: 20'h1, valid: 1'b1, present: 1'b1, writable: 1'b0};
      tlb[3] = '{vpn: 20'h00999, pfn: 20'h6, valid: 1'b1, present: 1'b0, writable: 1'b1};
      // Shadowed by entry 0
      tlb[4] = '{vpn: 20'h12345, pfn: 20'h7, valid: 1'b1, present: 1'b1, writable: 1'b1};
      tlb[6] = '{vpn: 20'h55555, pfn: 20'h2, valid: 1'b0, present: 1'b1, writable: 1'b1};
   endtask

   task automatic finish_row();
      tests_run++;
      if (row_errors == 0) begin
         $display("test %s: pass", cur_name);
      end else begin
         failed_tests++;
         $display("test %s: fail with %0d problems", cur_name, row_errors);
      end
   endtask

   `include "dcache_tb_table.svh"

   initial begin
      clk          = 1'b0;
      rst_i        = 1'b1;
      rd_valid_i   = 1'b0;
      rd_vaddr_i   = '0;
      rd_payload_i = '0;
      wb_valid_i   = 1'b0;
      wb_vaddr_i   = '0;
      wb_payload_i = '0;
      failed_tests = 0;
      tests_run    = 0;
      load_tlb();
      load_tests();
      repeat (16) @(posedge clk);
      #2;
      rst_i = 1'b0;

      cur_name   = "reset_state";
      row_errors = 0;
      @(negedge clk);
      compare_value("resp_valid_o", 64'd0, 64'(resp_valid_o));
      compare_value("full flags", 64'd0, 64'({rdaq_full_o, wbaq_full_o}));
      compare_value("aq_empty_o", 64'd1, 64'(aq_empty_o));
      compare_value("exception pulses", 64'd0, 64'(pulse_bits()));
      finish_row();

      for (int i = 0; i < rows.size(); i++) begin
         cur_name   = row_names[i];
         row_errors = 0;
         if (rows[i].op == OP_BURST) begin
            run_burst(rows[i]);
         end else begin
            send_request(rows[i]);
            check_pulses(rows[i]);
            if (rows[i].exc != NO_EXC) begin
               expect_quiet(6);
            end else if (rows[i].op == OP_WR) begin
               wait_drained();
            end else begin
               check_response(rows[i], rows[i].value[ID_W-1:0]);
            end
         end
         finish_row();
      end

      $display("tests %0d, passed %0d, failed %0d", tests_run, tests_run - failed_tests,
               failed_tests);
      if (failed_tests == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+dv
hw/dcache_pkg.sv
hw/tlb_lookup.sv
hw/access_queue.sv
hw/queue_arbiter.sv
hw/cache_bank.sv
hw/output_align.sv
hw/dcache_top.sv
dv/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sources.f --top-module dcache_tb -Mdir obj_dir

sim_out="$(./obj_dir/Vdcache_tb)"
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
